// ==== build.f ====
verilog/host_domain_pkg.sv
verilog/host_bus_if.sv
verilog/host_xbar.sv
verilog/l2_subsystem.sv
verilog/periph_regs.sv
verilog/edge_propagator_rx.sv
verilog/host_domain.sv
sim/host_domain_assertions.sv
sim/tb_host_domain.sv

// ==== run.sh ====
#!/bin/sh
# Build the host domain testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_host_domain -o tb_host_domain || exit 1
out=$(./obj_dir/tb_host_domain)
echo "$out"
echo "$out" | grep -q "Verification passed" && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// ==== sim/host_domain_assertions.sv ====
module host_domain_assertions import host_domain_pkg::*; (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              host_req_valid_i,
  input logic              host_req_ready_o,
  input logic              host_resp_valid_o,
  input logic              host_resp_ready_i,
  input logic [DATA_W-1:0] host_rdata_o,
  input logic              host_err_o,
  input logic              cluster_fetch_en_o,
  input logic              cluster_en_sa_boot_o,
  input logic              cluster_evt_ack_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Response payload holds while the host stalls
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp_valid_o && !host_resp_ready_i |=>
      host_resp_valid_o && $stable(host_rdata_o) && $stable(host_err_o))
    else $error("response changed before it was taken");

  // One request in flight at a time
  no_accept_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp_valid_o |-> !host_req_ready_o)
    else $error("request ready high while a response is pending");

  // Response comes exactly one cycle after acceptance
  resp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_req_valid_i && host_req_ready_o |-> !host_resp_valid_o ##1 host_resp_valid_o)
    else $error("response did not follow acceptance by one cycle");

  reset_values: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !cluster_fetch_en_o && !cluster_en_sa_boot_o &&
      !cluster_evt_ack_o && !host_resp_valid_o && host_req_ready_o)
    else $error("outputs not at their reset values");

endmodule

bind host_domain host_domain_assertions i_host_domain_assertions (.*);

// ==== sim/tb_host_domain.sv ====
module tb_host_domain import host_domain_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        chk_data;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } vec_t;

  localparam int N_VEC  = 20;
  localparam int N_RAND = 64;
  localparam int N_EVT  = 5;
  // Table, random write/read pairs, event toggles and four count accesses
  localparam int N_TXN      = N_VEC + 2 * N_RAND + N_EVT + 4;
  localparam int MAX_CYCLES = 20 * N_TXN + 200;

  // we, addr, wdata, check rdata, expected rdata, expected err
  localparam vec_t VECTORS [N_VEC] = '{
    '{1'b1, 32'h1000_0000, 32'haaaa_0000, 1'b0, 32'h0, 1'b0},
    '{1'b1, 32'h1000_0004, 32'haaaa_0001, 1'b0, 32'h0, 1'b0},
    '{1'b1, 32'h1000_0008, 32'haaaa_0002, 1'b0, 32'h0, 1'b0},
    '{1'b1, 32'h1000_000c, 32'haaaa_0003, 1'b0, 32'h0, 1'b0},
    '{1'b0, 32'h1000_0000, 32'h0, 1'b1, 32'haaaa_0000, 1'b0},
    '{1'b0, 32'h1000_0004, 32'h0, 1'b1, 32'haaaa_0001, 1'b0},
    '{1'b0, 32'h1000_0008, 32'h0, 1'b1, 32'haaaa_0002, 1'b0},
    '{1'b0, 32'h1abc_d00c, 32'h0, 1'b1, 32'haaaa_0003, 1'b0},
    '{1'b1, 32'h1fff_f3f0, 32'h5555_1234, 1'b0, 32'h0, 1'b0},
    '{1'b0, 32'h1000_03f0, 32'h0, 1'b1, 32'h5555_1234, 1'b0},
    '{1'b1, 32'h2000_0004, 32'hcafe_f00d, 1'b0, 32'h0, 1'b0},
    '{1'b0, 32'h2123_4564, 32'h0, 1'b1, 32'hcafe_f00d, 1'b0},
    '{1'b0, 32'h2000_000c, 32'h0, 1'b1, HOST_DOMAIN_ID, 1'b0},
    '{1'b1, 32'h2000_000c, 32'h1234_5678, 1'b0, 32'h0, 1'b1},
    '{1'b0, 32'h2000_000c, 32'h0, 1'b1, HOST_DOMAIN_ID, 1'b0},
    '{1'b0, 32'h3000_0000, 32'h0, 1'b1, 32'h0, 1'b1},
    '{1'b1, 32'h3000_0010, 32'hffff_ffff, 1'b1, 32'h0, 1'b1},
    '{1'b0, 32'h0000_0000, 32'h0, 1'b1, 32'h0, 1'b1},
    '{1'b1, 32'h2000_0000, 32'h0000_0003, 1'b0, 32'h0, 1'b0},
    '{1'b0, 32'h2000_0000, 32'h0, 1'b1, 32'h0000_0003, 1'b0}
  };

  logic        clk_i;
  logic        rst_n_i;
  logic        host_req_valid_i;
  logic        host_req_ready_o;
  logic [31:0] host_addr_i;
  logic        host_we_i;
  logic [31:0] host_wdata_i;
  logic        host_resp_valid_o;
  logic        host_resp_ready_i;
  logic [31:0] host_rdata_o;
  logic        host_err_o;
  logic        cluster_evt_valid_i;
  logic        cluster_evt_ack_o;
  logic        cluster_fetch_en_o;
  logic        cluster_en_sa_boot_o;

  integer seed   = 32'hd60a_58ee;
  int     cycles = 0;

  // Reference L2 contents by word index
  logic [31:0] model [logic [9:0]];
  logic [9:0]  written [$];

  host_domain i_host_domain (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Starts and ends on a rising edge
  task automatic run_txn(input logic w, input logic [31:0] a, input logic [31:0] d,
                         output logic [31:0] rdata, output logic err);
    logic [31:0] rnd;
    host_req_valid_i <= 1'b1;
    host_we_i        <= w;
    host_addr_i      <= a;
    host_wdata_i     <= d;
    do @(posedge clk_i); while (!host_req_ready_o);
    host_req_valid_i <= 1'b0;
    rnd = $random(seed);
    host_resp_ready_i <= rnd[0];
    @(posedge clk_i);
    // Due exactly one cycle after acceptance
    check_value("host_resp_valid_o", 32'd1, 32'(host_resp_valid_o));
    rdata = host_rdata_o;
    err   = host_err_o;
    while (!host_resp_ready_i) begin
      check_value("host_req_ready_o", 32'd0, 32'(host_req_ready_o));
      check_value("host_resp_valid_o", 32'd1, 32'(host_resp_valid_o));
      check_value("host_rdata_o", rdata, host_rdata_o);
      rnd = $random(seed);
      host_resp_ready_i <= rnd[0];
      @(posedge clk_i);
    end
    host_resp_ready_i <= 1'b0;
  endtask

  task automatic toggle_event();
    cluster_evt_valid_i <= ~cluster_evt_valid_i;
    do @(posedge clk_i); while (cluster_evt_ack_o !== cluster_evt_valid_i);
  endtask

  initial begin
    logic [31:0] rd;
    logic        er;
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] d;
    logic [9:0]  k;
    int          pick;
    rst_n_i             = 1'b0;
    host_req_valid_i    = 1'b0;
    host_addr_i         = '0;
    host_we_i           = 1'b0;
    host_wdata_i        = '0;
    host_resp_ready_i   = 1'b0;
    cluster_evt_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    foreach (VECTORS[i]) begin
      run_txn(VECTORS[i].we, VECTORS[i].addr, VECTORS[i].wdata, rd, er);
      check_value("host_err_o", 32'(VECTORS[i].exp_err), 32'(er));
      if (VECTORS[i].chk_data) check_value("host_rdata_o", VECTORS[i].exp_rdata, rd);
    end
    check_value("cluster_fetch_en_o", 32'd1, 32'(cluster_fetch_en_o));
    check_value("cluster_en_sa_boot_o", 32'd1, 32'(cluster_en_sa_boot_o));

    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      a   = {REGION_L2_BASE, rnd[27:2], 2'b00};
      d   = $random(seed);
      run_txn(1'b1, a, d, rd, er);
      check_value("host_err_o", 32'd0, 32'(er));
      model[a[11:2]] = d;
      written.push_back(a[11:2]);
      // Read back some written word through different upper address bits
      rnd  = $random(seed);
      pick = int'(rnd[15:0]) % written.size();
      k    = written[pick];
      run_txn(1'b0, {REGION_L2_BASE, rnd[31:16], k, 2'b00}, 32'h0, rd, er);
      check_value("host_err_o", 32'd0, 32'(er));
      check_value("host_rdata_o", model[k], rd);
    end

    run_txn(1'b0, 32'h2000_0008, 32'h0, rd, er);
    check_value("host_rdata_o", 32'd0, rd);
    repeat (N_EVT) toggle_event();
    run_txn(1'b0, 32'h2000_0008, 32'h0, rd, er);
    check_value("host_err_o", 32'd0, 32'(er));
    check_value("host_rdata_o", 32'(N_EVT), rd);
    run_txn(1'b1, 32'h2000_0008, 32'hdead_beef, rd, er);
    run_txn(1'b0, 32'h2000_0008, 32'h0, rd, er);
    check_value("host_rdata_o", 32'd0, rd);

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== verilog/edge_propagator_rx.sv ====
module edge_propagator_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic [1:0] sync_q;
  logic       level_q;

  // Two-stage synchronizer, then one flop for the previous level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q  <= '0;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      level_q <= sync_q[1];
    end
  end

  // Any change of the toggle level is one event
  assign valid_o = sync_q[1] ^ level_q;

  // Sender compares this with its own toggle
  assign ack_o = sync_q[1];

endmodule

// ==== verilog/host_bus_if.sv ====
interface host_bus_if import host_domain_pkg::*; ();

  // Request channel
  logic              req_valid;
  logic              req_ready;
  logic [ADDR_W-1:0] addr;
  logic              we;
  logic [DATA_W-1:0] wdata;

  // Response channel
  logic              resp_valid;
  logic              resp_ready;
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport master (
    output req_valid, addr, we, wdata, resp_ready,
    input  req_ready, resp_valid, rdata, err
  );

  modport slave (
    input  req_valid, addr, we, wdata, resp_ready,
    output req_ready, resp_valid, rdata, err
  );

endinterface

// ==== verilog/host_domain.sv ====
module host_domain import host_domain_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              host_req_valid_i,
  output logic              host_req_ready_o,
  input  logic [ADDR_W-1:0] host_addr_i,
  input  logic              host_we_i,
  input  logic [DATA_W-1:0] host_wdata_i,
  output logic              host_resp_valid_o,
  input  logic              host_resp_ready_i,
  output logic [DATA_W-1:0] host_rdata_o,
  output logic              host_err_o,
  input  logic              cluster_evt_valid_i,
  output logic              cluster_evt_ack_o,
  output logic              cluster_fetch_en_o,
  output logic              cluster_en_sa_boot_o
);

  logic evt_pulse;

  host_bus_if l2_bus ();
  host_bus_if periph_bus ();

  host_xbar i_host_xbar (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .host_req_valid_i  ( host_req_valid_i  ),
    .host_req_ready_o  ( host_req_ready_o  ),
    .host_addr_i       ( host_addr_i       ),
    .host_we_i         ( host_we_i         ),
    .host_wdata_i      ( host_wdata_i      ),
    .host_resp_valid_o ( host_resp_valid_o ),
    .host_resp_ready_i ( host_resp_ready_i ),
    .host_rdata_o      ( host_rdata_o      ),
    .host_err_o        ( host_err_o        ),
    .l2_bus            ( l2_bus            ),
    .periph_bus        ( periph_bus        )
  );

  l2_subsystem i_l2_subsystem (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .bus     ( l2_bus  )
  );

  periph_regs i_periph_regs (
    .clk_i                ( clk_i                ),
    .rst_n_i              ( rst_n_i              ),
    .evt_pulse_i          ( evt_pulse            ),
    .cluster_fetch_en_o   ( cluster_fetch_en_o   ),
    .cluster_en_sa_boot_o ( cluster_en_sa_boot_o ),
    .bus                  ( periph_bus           )
  );

  // Cluster event crosses into the host clock here
  edge_propagator_rx i_ep_cluster_evt (
    .clk_i   ( clk_i               ),
    .rst_n_i ( rst_n_i             ),
    .valid_i ( cluster_evt_valid_i ),
    .valid_o ( evt_pulse           ),
    .ack_o   ( cluster_evt_ack_o   )
  );

endmodule

// ==== verilog/host_domain_pkg.sv ====
package host_domain_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // L2 organisation, word interleaved across banks
  localparam int unsigned NB_L2_BANKS   = 4;
  localparam int unsigned L2_BANK_WORDS = 256;
  localparam int unsigned L2_BANK_SEL_W = $clog2(NB_L2_BANKS);
  localparam int unsigned L2_ROW_W      = $clog2(L2_BANK_WORDS);

  // Region select on address bits 31..28
  localparam int unsigned REGION_W           = 4;
  localparam logic [3:0]  REGION_L2_BASE     = 4'h1;
  localparam logic [3:0]  REGION_PERIPH_BASE = 4'h2;

  localparam logic [31:0] HOST_DOMAIN_ID = 32'h4057_D001;

  // Register word offsets, address bits 3..2
  typedef enum logic [1:0] {
    REG_CTRL      = 2'd0,
    REG_SCRATCH   = 2'd1,
    REG_EVT_COUNT = 2'd2,
    REG_ID        = 2'd3
  } periph_reg_e;

  typedef enum logic {
    XBAR_IDLE,
    XBAR_WAIT_RESP
  } xbar_state_e;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_PERIPH,
    TGT_NONE
  } host_target_e;

endpackage

// ==== verilog/host_xbar.sv ====
module host_xbar import host_domain_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              host_req_valid_i,
  output logic              host_req_ready_o,
  input  logic [ADDR_W-1:0] host_addr_i,
  input  logic              host_we_i,
  input  logic [DATA_W-1:0] host_wdata_i,
  output logic              host_resp_valid_o,
  input  logic              host_resp_ready_i,
  output logic [DATA_W-1:0] host_rdata_o,
  output logic              host_err_o,
  host_bus_if.master        l2_bus,
  host_bus_if.master        periph_bus
);

  xbar_state_e  state_q, state_d;
  host_target_e tgt_dec, tgt_q;
  logic         idle;
  logic         slave_ready;
  logic         req_fire;
  logic         resp_fire;

  // Region decode on the top address nibble
  always_comb begin
    case (host_addr_i[ADDR_W-1 -: REGION_W])
      REGION_L2_BASE:     tgt_dec = TGT_L2;
      REGION_PERIPH_BASE: tgt_dec = TGT_PERIPH;
      default:            tgt_dec = TGT_NONE;
    endcase
  end

  assign idle = (state_q == XBAR_IDLE);

  // Payload goes to both targets, only valid is steered
  assign l2_bus.addr      = host_addr_i;
  assign l2_bus.we        = host_we_i;
  assign l2_bus.wdata     = host_wdata_i;
  assign l2_bus.req_valid = idle && host_req_valid_i && (tgt_dec == TGT_L2);

  assign periph_bus.addr      = host_addr_i;
  assign periph_bus.we        = host_we_i;
  assign periph_bus.wdata     = host_wdata_i;
  assign periph_bus.req_valid = idle && host_req_valid_i && (tgt_dec == TGT_PERIPH);

  always_comb begin
    case (tgt_dec)
      TGT_L2:     slave_ready = l2_bus.req_ready;
      TGT_PERIPH: slave_ready = periph_bus.req_ready;
      // Unmapped requests are taken at once
      default:    slave_ready = 1'b1;
    endcase
  end

  assign host_req_ready_o = idle && slave_ready;
  assign req_fire         = host_req_valid_i && host_req_ready_o;

  // Response mux on the latched target
  always_comb begin
    case (tgt_q)
      TGT_L2: begin
        host_resp_valid_o = !idle && l2_bus.resp_valid;
        host_rdata_o      = l2_bus.rdata;
        host_err_o        = l2_bus.err;
      end
      TGT_PERIPH: begin
        host_resp_valid_o = !idle && periph_bus.resp_valid;
        host_rdata_o      = periph_bus.rdata;
        host_err_o        = periph_bus.err;
      end
      default: begin
        host_resp_valid_o = !idle;
        host_rdata_o      = '0;
        host_err_o        = 1'b1;
      end
    endcase
  end

  assign l2_bus.resp_ready     = !idle && (tgt_q == TGT_L2) && host_resp_ready_i;
  assign periph_bus.resp_ready = !idle && (tgt_q == TGT_PERIPH) && host_resp_ready_i;
  assign resp_fire             = host_resp_valid_o && host_resp_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      XBAR_IDLE:      if (req_fire) state_d = XBAR_WAIT_RESP;
      XBAR_WAIT_RESP: if (resp_fire) state_d = XBAR_IDLE;
      default:        state_d = XBAR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= XBAR_IDLE;
      tgt_q   <= TGT_NONE;
    end else begin
      state_q <= state_d;
      if (req_fire) tgt_q <= tgt_dec;
    end
  end

endmodule

// ==== verilog/l2_subsystem.sv ====
module l2_subsystem import host_domain_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  host_bus_if.slave bus
);

  logic [L2_BANK_SEL_W-1:0] bank_sel;
  logic [L2_ROW_W-1:0]      row;
  logic [L2_BANK_SEL_W-1:0] bank_q;
  logic [DATA_W-1:0]        bank_rdata_q [NB_L2_BANKS];
  logic                     resp_valid_q;
  logic                     req_fire;

  // Consecutive words land in consecutive banks
  assign bank_sel = bus.addr[2 +: L2_BANK_SEL_W];
  assign row      = bus.addr[2 + L2_BANK_SEL_W +: L2_ROW_W];

  assign bus.req_ready = !resp_valid_q;
  assign req_fire      = bus.req_valid && bus.req_ready;

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : gen_bank
    logic [DATA_W-1:0] mem_q [L2_BANK_WORDS];
    logic              bank_req;

    assign bank_req = req_fire && (bank_sel == L2_BANK_SEL_W'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (bus.we) mem_q[row] <= bus.wdata;
        else        bank_rdata_q[b] <= mem_q[row];
      end
    end
  end

  // Bank of the pending access selects the read data
  always_ff @(posedge clk_i) begin
    if (req_fire) bank_q <= bank_sel;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (bus.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign bus.resp_valid = resp_valid_q;
  assign bus.rdata      = bank_rdata_q[bank_q];
  assign bus.err        = 1'b0;

endmodule

// ==== verilog/periph_regs.sv ====
module periph_regs import host_domain_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      evt_pulse_i,
  output logic      cluster_fetch_en_o,
  output logic      cluster_en_sa_boot_o,
  host_bus_if.slave bus
);

  periph_reg_e       reg_off;
  logic              req_fire;
  logic              wr_fire;
  logic [1:0]        ctrl_q;
  logic [DATA_W-1:0] scratch_q;
  logic [DATA_W-1:0] evt_count_q;
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;
  logic              resp_valid_q;

  // Only bits 3..2 pick the register, the rest aliases
  assign reg_off = periph_reg_e'(bus.addr[3:2]);

  assign bus.req_ready = !resp_valid_q;
  assign req_fire      = bus.req_valid && bus.req_ready;
  assign wr_fire       = req_fire && bus.we;

  always_comb begin
    case (reg_off)
      REG_CTRL:      rd_data = {{(DATA_W-2){1'b0}}, ctrl_q};
      REG_SCRATCH:   rd_data = scratch_q;
      REG_EVT_COUNT: rd_data = evt_count_q;
      default:       rd_data = HOST_DOMAIN_ID;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q       <= '0;
      evt_count_q  <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      if (req_fire) resp_valid_q <= 1'b1;
      else if (bus.resp_ready) resp_valid_q <= 1'b0;

      if (wr_fire && reg_off == REG_CTRL) ctrl_q <= bus.wdata[1:0];

      // A clearing write wins over a same-cycle event
      if (wr_fire && reg_off == REG_EVT_COUNT) evt_count_q <= '0;
      else if (evt_pulse_i) evt_count_q <= evt_count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rdata_q <= bus.we ? '0 : rd_data;
      err_q   <= bus.we && (reg_off == REG_ID);
    end
    if (wr_fire && reg_off == REG_SCRATCH) scratch_q <= bus.wdata;
  end

  assign bus.resp_valid = resp_valid_q;
  assign bus.rdata      = rdata_q;
  assign bus.err        = err_q;

  assign cluster_fetch_en_o   = ctrl_q[0];
  assign cluster_en_sa_boot_o = ctrl_q[1];

endmodule
